/* files.f */
psx_mem_pkg.sv
psx_cfg_pkg.sv
download_unpacker.sv
ram_write_arbiter.sv
media_tracker.sv
video_config.sv
psx_host_bridge.sv
host_bridge_properties.sv
tb_psx_host_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the host bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_psx_host_bridge \
	-f files.f -o sim_tb \
	&& ./obj_dir/sim_tb 2>&1 | tee sim.log \
	|| { echo "Build or simulation did not complete"; exit 1; }

grep -qx "PASS: all tests" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

/* tb_psx_host_bridge.sv */
// PSX host bridge testbench
// Directed tests for downloads, core pass-through, media and video setup
`timescale 1ns/1ps

module tb_psx_host_bridge;
	import psx_mem_pkg::*;
	import psx_cfg_pkg::*;

	localparam int TIMEOUT_CYCLES = 32;

	logic          clk_1x;
	logic          arst_n;
	logic          ioctl_download;
	logic [7:0]    ioctl_index;
	logic          ioctl_wr;
	ram_addr_t     ioctl_addr;
	logic [15:0]   ioctl_dout;
	logic          ioctl_wait;
	logic          load_exe;
	logic [3:0]    img_mounted;
	logic [63:0]   img_size;
	host_status_t  status;
	logic          osd_status;
	media_state_t  media;
	logic          mc1_load;
	logic          mc2_load;
	logic          mc_save;
	logic          cart_loaded;
	display_geom_t geom;
	logic          video_interlace;
	fb_cfg_t       fb_cfg;
	aspect_t       aspect;
	logic [1:0]    vga_sl;
	logic          vga_f1;
	core_ram_req_t core_req;
	logic          core_ack;
	logic          sdram_rd_req;
	ram_addr_t     sdram_rd_addr;
	logic          sdram_rd_ack = 1'b0;
	ram_wr_t       sdram_wr;
	logic          sdram_wr_ack = 1'b0;

	integer  seed = 43852;
	ram_wr_t wr_log[$];

	psx_host_bridge #(
		.BIOS_START (BIOS_BASE),
		.EXE_START  (EXE_BASE),
		.FB_BASE    (FB_BASE_ADDR),
		.FB_STRIDE  (FB_STRIDE_BYTES)
	) DUT (.*);

	initial clk_1x = 1'b0;
	always #4 clk_1x = ~clk_1x;

	// ==================================================
	// Error reporting and RAM model
	// ==================================================

	task automatic report_error(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		$display("FAIL: see errors above");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t ns while waiting for %s", $time, what);
		$display("FAIL: see errors above");
		$fatal(1, "Stopped at the first error");
	endtask

	function automatic int ack_delay();
		logic [31:0] r;
		r = $random(seed);
		return 1 + int'(r[1:0]);
	endfunction

	// Write channel model logs each request and acks it 1 to 4 cycles later
	always begin : wr_model
		int delay;
		@(posedge clk_1x);
		if (arst_n && sdram_wr.req) begin
			wr_log.push_back(sdram_wr);
			delay = ack_delay();
			repeat (delay - 1) @(posedge clk_1x);
			sdram_wr_ack <= 1'b1;
			@(posedge clk_1x);
			sdram_wr_ack <= 1'b0;
		end
	end

	always begin : rd_model
		int delay;
		@(posedge clk_1x);
		if (arst_n && sdram_rd_req) begin
			delay = ack_delay();
			repeat (delay - 1) @(posedge clk_1x);
			sdram_rd_ack <= 1'b1;
			@(posedge clk_1x);
			sdram_rd_ack <= 1'b0;
		end
	end

	task automatic check_logged_write(input ram_addr_t addr, input logic [31:0] data,
			input logic [3:0] be);
		ram_wr_t got;
		assert (wr_log.size() == 1)
			else report_error($sformatf("expected one RAM write, saw %0d", wr_log.size()));
		got = wr_log.pop_front();
		assert (got.addr == addr && got.data == data && got.be == be)
			else report_error($sformatf("RAM write %h/%h/%b, expected %h/%h/%b",
				got.addr, got.data, got.be, addr, data, be));
	endtask

	// ==================================================
	// Download tests
	// ==================================================

	task automatic send_word_pair(input ram_addr_t addr, input logic [15:0] lo,
			input logic [15:0] hi);
		@(posedge clk_1x);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= addr;
		ioctl_dout <= lo;
		@(posedge clk_1x);
		ioctl_addr <= addr + 27'd2;
		ioctl_dout <= hi;
		@(posedge clk_1x);
		ioctl_wr <= 1'b0;
	endtask

	// Host stays stalled until the RAM has taken the word
	task automatic wait_host_release();
		int   cycles;
		logic acked;
		acked  = 1'b0;
		cycles = 0;
		do begin
			@(posedge clk_1x);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				report_timeout("ioctl_wait to fall after the write ack");
			end
			if (!acked) begin
				assert (ioctl_wait)
					else report_error("ioctl_wait low before the write ack");
			end
			acked = acked | sdram_wr_ack;
		end while (ioctl_wait || !acked);
	endtask

	task automatic image_download(input logic [7:0] index, input ram_addr_t base,
			output int pulses, output int first);
		logic [31:0] r;
		ram_addr_t   a;
		@(posedge clk_1x);
		ioctl_download <= 1'b1;
		ioctl_index    <= index;
		repeat (2) @(posedge clk_1x);
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			a = 27'(32'h0400 + i * 4);
			send_word_pair(a, r[15:0], r[31:16]);
			wait_host_release();
			check_logged_write(base + a, r, 4'b1111);
		end
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		pulses = 0;
		first  = 0;
		for (int i = 1; i <= 8; i++) begin
			@(posedge clk_1x);
			if (load_exe) begin
				pulses++;
				if (first == 0) begin
					first = i;
				end
			end
		end
	endtask

	task automatic bios_download();
		int pulses;
		int first;
		image_download(IDX_BIOS, BIOS_BASE, pulses, first);
		assert (pulses == 0) else report_error("load_exe pulsed after a BIOS download");
	endtask

	task automatic exe_download();
		int pulses;
		int first;
		image_download(IDX_EXE, EXE_BASE, pulses, first);
		assert (pulses == 1 && first <= 4)
			else report_error($sformatf("load_exe pulses %0d, first after %0d cycles",
				pulses, first));
	endtask

	// ==================================================
	// Core pass-through
	// ==================================================

	task automatic core_access(input logic rnw);
		core_ram_req_t req;
		logic [31:0]   r;
		int            cycles;
		r        = $random(seed);
		req.ena  = 1'b1;
		req.rnw  = rnw;
		req.addr = r[26:0];
		req.be   = r[30:27];
		req.data = $random(seed);
		@(posedge clk_1x);
		core_req <= req;
		cycles = 0;
		do begin
			@(posedge clk_1x);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				report_timeout("the core request ack");
			end
			if (rnw) begin
				assert (sdram_rd_req && sdram_rd_addr == req.addr && !sdram_wr.req)
					else report_error("core read not on the read channel");
			end else begin
				assert (sdram_wr.req && !sdram_rd_req && sdram_wr.addr == req.addr
						&& sdram_wr.data == req.data && sdram_wr.be == req.be)
					else report_error("core write not on the write channel");
			end
			assert (core_ack == (sdram_rd_ack | sdram_wr_ack))
				else report_error("core_ack does not follow the RAM acks");
		end while (!core_ack);
		core_req.ena <= 1'b0;
		if (rnw) begin
			assert (wr_log.size() == 0)
				else report_error("core read caused a RAM write");
		end else begin
			check_logged_write(req.addr, req.data, req.be);
		end
	endtask

	task automatic core_passthrough();
		for (int i = 0; i < 6; i++) begin
			core_access(i[0]);
		end
	endtask

	// ==================================================
	// Media and menu pulses
	// ==================================================

	task automatic mount_image(input int slot, input logic [63:0] size);
		@(posedge clk_1x);
		img_mounted <= 4'b0001 << slot;
		img_size    <= size;
		@(posedge clk_1x);
		img_mounted <= 4'b0000;
	endtask

	task automatic count_pulses(input int cycles, output int n1, output int n2,
			output int ns);
		n1 = 0;
		n2 = 0;
		ns = 0;
		repeat (cycles) begin
			@(posedge clk_1x);
			n1 += int'(mc1_load);
			n2 += int'(mc2_load);
			ns += int'(mc_save);
		end
	endtask

	task automatic media_mounts();
		int          n1;
		int          n2;
		int          ns;
		logic [63:0] cd_bytes;
		cd_bytes = 64'h0000_0004_2345_6789;
		mount_image(1, cd_bytes);
		count_pulses(4, n1, n2, ns);
		assert (media.has_cd && media.cd_hps_on && media.cd_size == cd_bytes[29:0])
			else report_error($sformatf("CD mount gave media %h", media));
		assert (cart_loaded && n1 == 0 && n2 == 0)
			else report_error("CD mount side effects");
		mount_image(2, 64'd131072);
		count_pulses(4, n1, n2, ns);
		assert (media.mc1_mounted && !media.mc2_mounted && n1 == 1 && n2 == 0)
			else report_error($sformatf("card 1 mount, loads %0d/%0d", n1, n2));
		mount_image(3, 64'd131072);
		count_pulses(4, n1, n2, ns);
		assert (media.mc2_mounted && n1 == 0 && n2 == 1)
			else report_error($sformatf("card 2 mount, loads %0d/%0d", n1, n2));
		// Unmounts
		mount_image(2, 64'd0);
		count_pulses(4, n1, n2, ns);
		assert (!media.mc1_mounted && media.mc2_mounted && n1 == 0)
			else report_error("card 1 unmount");
		mount_image(1, 64'd0);
		count_pulses(4, n1, n2, ns);
		assert (!media.has_cd) else report_error("CD unmount left has_cd set");
	endtask

	task automatic load_save_pulses();
		int n1;
		int n2;
		int ns;
		@(posedge clk_1x);
		status.bk_load <= 1'b1;
		count_pulses(8, n1, n2, ns);
		assert (n1 == 1 && n2 == 1 && ns == 0)
			else report_error($sformatf("bk_load gave %0d/%0d/%0d pulses", n1, n2, ns));
		@(posedge clk_1x);
		status.bk_load <= 1'b0;
		status.bk_save <= 1'b1;
		count_pulses(8, n1, n2, ns);
		assert (n1 == 0 && n2 == 0 && ns == 1)
			else report_error($sformatf("bk_save gave %0d/%0d/%0d pulses", n1, n2, ns));
		@(posedge clk_1x);
		status.bk_save     <= 1'b0;
		status.bk_autosave <= 1'b1;
		count_pulses(4, n1, n2, ns);
		assert (ns == 0) else report_error("autosave enable alone gave mc_save");
		@(posedge clk_1x);
		osd_status <= 1'b1;
		count_pulses(8, n1, n2, ns);
		assert (ns == 1)
			else report_error($sformatf("autosave gave %0d mc_save pulses", ns));
		@(posedge clk_1x);
		osd_status         <= 1'b0;
		status.bk_autosave <= 1'b0;
	endtask

	// ==================================================
	// Video configuration
	// ==================================================

	task automatic check_video(input host_status_t opt, input display_geom_t g,
			input logic ilace);
		fb_cfg_t     fb;
		aspect_t     ar;
		logic [1:0]  sl;
		fb.en     = opt.fb_enable;
		fb.format = opt.fb_24bit ? 5'b00101 : 5'b01100;
		fb.width  = opt.vram_viewer ? 12'd1024 : g.width;
		fb.height = opt.vram_viewer ? 12'd512 : g.height;
		fb.base   = FB_BASE_ADDR;
		if (!opt.vram_viewer) begin
			fb.base = FB_BASE_ADDR + 32'd2 * 32'(g.offset_x)
				+ FB_STRIDE_BYTES * 32'(g.offset_y);
		end
		if (opt.aspect == 2'd0) begin
			ar.arx = opt.vram_viewer ? 13'd2 : 13'd4;
			ar.ary = opt.vram_viewer ? 13'd1 : 13'd3;
		end else begin
			ar.arx = {11'd0, opt.aspect} - 13'd1;
			ar.ary = 13'd0;
		end
		sl = (opt.scale == 3'd0) ? 2'd0 : 2'(opt.scale - 3'd1);
		assert (fb_cfg == fb)
			else report_error($sformatf("fb_cfg %h, expected %h", fb_cfg, fb));
		assert (aspect == ar)
			else report_error($sformatf("aspect %h, expected %h", aspect, ar));
		assert (vga_sl == sl && vga_f1 == (ilace & ~opt.deint_bob & ~opt.fb_enable))
			else report_error($sformatf("vga_sl %0d vga_f1 %b", vga_sl, vga_f1));
	endtask

	task automatic video_options();
		host_status_t  opt;
		display_geom_t g;
		logic [31:0]   r;
		for (int i = 0; i < 40; i++) begin
			r = $random(seed);
			opt             = host_status_t'(r[$bits(host_status_t)-1:0]);
			opt.bk_load     = 1'b0;
			opt.bk_save     = 1'b0;
			opt.bk_autosave = 1'b0;
			g.width  = r[26:15];
			r = $random(seed);
			g.height   = r[11:0];
			g.offset_x = r[21:12];
			g.offset_y = r[30:22];
			@(posedge clk_1x);
			status          <= opt;
			geom            <= g;
			video_interlace <= r[31];
			repeat (2) @(posedge clk_1x);
			check_video(opt, g, r[31]);
		end
	endtask

	initial begin
		arst_n          <= 1'b0;
		ioctl_download  <= 1'b0;
		ioctl_index     <= 8'd0;
		ioctl_wr        <= 1'b0;
		ioctl_addr      <= '0;
		ioctl_dout      <= 16'd0;
		img_mounted     <= 4'd0;
		img_size        <= 64'd0;
		status          <= '0;
		osd_status      <= 1'b0;
		geom            <= '0;
		video_interlace <= 1'b0;
		core_req        <= '0;
		repeat (16) @(posedge clk_1x);
		assert (!ioctl_wait && !sdram_wr.req && !load_exe && media == '0 && !mc1_load
				&& !mc2_load && !mc_save && !cart_loaded && !fb_cfg.en)
			else report_error("outputs not cleared during reset");
		arst_n <= 1'b1;
		repeat (2) @(posedge clk_1x);
		media_mounts();
		load_save_pulses();
		bios_download();
		exe_download();
		core_passthrough();
		video_options();
		repeat (4) @(posedge clk_1x);
		$display("PASS: all tests");
		$finish;
	end

endmodule

/* host_bridge_properties.sv */
// Host bridge protocol checks
// Strobe widths, host stall and download write ordering
`timescale 1ns/1ps

module host_bridge_properties (
	input logic                 clk_1x,
	input logic                 arst_n,
	input logic                 dl_active,
	input psx_mem_pkg::ram_wr_t sdram_wr,
	input logic                 sdram_wr_ack,
	input logic                 ioctl_wait,
	input logic                 load_exe,
	input logic                 mc_save
);
	logic wr_pending;

	// Download write still waiting for its ack
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			wr_pending <= 1'b0;
		end else if (dl_active && sdram_wr.req) begin
			wr_pending <= 1'b1;
		end else if (sdram_wr_ack) begin
			wr_pending <= 1'b0;
		end
	end

	load_exe_single: assert property (@(posedge clk_1x) disable iff (!arst_n)
		load_exe |=> !load_exe) else $error("load_exe high on two cycles in a row");

	mc_save_single: assert property (@(posedge clk_1x) disable iff (!arst_n)
		mc_save |=> !mc_save) else $error("mc_save high on two cycles in a row");

	wr_req_single: assert property (@(posedge clk_1x) disable iff (!arst_n)
		(dl_active && sdram_wr.req) |=> !sdram_wr.req)
		else $error("download write request high on two cycles in a row");

	wait_held: assert property (@(posedge clk_1x) disable iff (!arst_n)
		(dl_active && ioctl_wait && !sdram_wr_ack) |=> ioctl_wait)
		else $error("ioctl_wait fell without a write ack or download end");

	no_overlap: assert property (@(posedge clk_1x) disable iff (!arst_n)
		(dl_active && sdram_wr.req) |-> !wr_pending)
		else $error("download write issued while the previous one is unacked");

endmodule

bind psx_host_bridge host_bridge_properties u_properties (
	.clk_1x       (clk_1x),
	.arst_n       (arst_n),
	.dl_active    (dl_active),
	.sdram_wr     (sdram_wr),
	.sdram_wr_ack (sdram_wr_ack),
	.ioctl_wait   (ioctl_wait),
	.load_exe     (load_exe),
	.mc_save      (mc_save)
);

/* psx_host_bridge.sv */
// PSX host bridge top level
// Download unpacking, SDRAM arbitration, media tracking and video setup
`timescale 1ns/1ps

module psx_host_bridge #(
	parameter psx_mem_pkg::ram_addr_t BIOS_START = psx_mem_pkg::BIOS_BASE,
	parameter psx_mem_pkg::ram_addr_t EXE_START  = psx_mem_pkg::EXE_BASE,
	parameter logic [31:0]            FB_BASE    = psx_cfg_pkg::FB_BASE_ADDR,
	parameter logic [31:0]            FB_STRIDE  = psx_cfg_pkg::FB_STRIDE_BYTES
) (
	input  logic                        clk_1x,
	input  logic                        arst_n,
	// Host download port
	input  logic                        ioctl_download,
	input  logic [7:0]                  ioctl_index,
	input  logic                        ioctl_wr,
	input  psx_mem_pkg::ram_addr_t      ioctl_addr,
	input  logic [15:0]                 ioctl_dout,
	output logic                        ioctl_wait,
	output logic                        load_exe,
	// Image mounts and menu
	input  logic [3:0]                  img_mounted,
	input  logic [63:0]                 img_size,
	input  psx_cfg_pkg::host_status_t   status,
	input  logic                        osd_status,
	output psx_cfg_pkg::media_state_t   media,
	output logic                        mc1_load,
	output logic                        mc2_load,
	output logic                        mc_save,
	output logic                        cart_loaded,
	// Video
	input  psx_cfg_pkg::display_geom_t  geom,
	input  logic                        video_interlace,
	output psx_cfg_pkg::fb_cfg_t        fb_cfg,
	output psx_cfg_pkg::aspect_t        aspect,
	output logic [1:0]                  vga_sl,
	output logic                        vga_f1,
	// Core and SDRAM
	input  psx_mem_pkg::core_ram_req_t  core_req,
	output logic                        core_ack,
	output logic                        sdram_rd_req,
	output psx_mem_pkg::ram_addr_t      sdram_rd_addr,
	input  logic                        sdram_rd_ack,
	output psx_mem_pkg::ram_wr_t        sdram_wr,
	input  logic                        sdram_wr_ack
);
	import psx_mem_pkg::*;

	ram_wr_t dl_wr;
	logic    dl_active;
	logic    exe_dl;

	download_unpacker #(
		.BIOS_START (BIOS_START),
		.EXE_START  (EXE_START)
	) u_unpacker (
		.clk_1x         (clk_1x),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.wr_ack         (sdram_wr_ack),
		.ioctl_wait     (ioctl_wait),
		.dl_wr          (dl_wr),
		.dl_active      (dl_active),
		.exe_dl         (exe_dl),
		.load_exe       (load_exe)
	);

	ram_write_arbiter u_arbiter (
		.dl_active     (dl_active),
		.dl_wr         (dl_wr),
		.core_req      (core_req),
		.sdram_rd_ack  (sdram_rd_ack),
		.sdram_wr_ack  (sdram_wr_ack),
		.sdram_rd_req  (sdram_rd_req),
		.sdram_rd_addr (sdram_rd_addr),
		.sdram_wr      (sdram_wr),
		.core_ack      (core_ack)
	);

	media_tracker u_media (
		.clk_1x      (clk_1x),
		.arst_n      (arst_n),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.status      (status),
		.osd_status  (osd_status),
		.exe_dl      (exe_dl),
		.media       (media),
		.mc1_load    (mc1_load),
		.mc2_load    (mc2_load),
		.mc_save     (mc_save),
		.cart_loaded (cart_loaded)
	);

	video_config #(
		.FB_BASE   (FB_BASE),
		.FB_STRIDE (FB_STRIDE)
	) u_video (
		.clk_1x          (clk_1x),
		.arst_n          (arst_n),
		.status          (status),
		.geom            (geom),
		.video_interlace (video_interlace),
		.fb_cfg          (fb_cfg),
		.aspect          (aspect),
		.vga_sl          (vga_sl),
		.vga_f1          (vga_f1)
	);

endmodule

/* video_config.sv */
// Video configuration
// Turns menu options and core geometry into framebuffer, aspect and
// scanline settings for the video output
`timescale 1ns/1ps

module video_config #(
	parameter logic [31:0] FB_BASE   = psx_cfg_pkg::FB_BASE_ADDR,
	parameter logic [31:0] FB_STRIDE = psx_cfg_pkg::FB_STRIDE_BYTES
) (
	input  logic                        clk_1x,
	input  logic                        arst_n,
	input  psx_cfg_pkg::host_status_t   status,
	input  psx_cfg_pkg::display_geom_t  geom,
	input  logic                        video_interlace,
	output psx_cfg_pkg::fb_cfg_t        fb_cfg,
	output psx_cfg_pkg::aspect_t        aspect,
	output logic [1:0]                  vga_sl,
	output logic                        vga_f1
);
	import psx_cfg_pkg::*;

	fb_cfg_t    fb_nxt;
	aspect_t    aspect_nxt;
	logic [2:0] sl_nxt;

	always_comb begin
		fb_nxt.en     = status.fb_enable;
		fb_nxt.format = status.fb_24bit ? FB_FMT_24BPP : FB_FMT_16BPP;
		if (status.vram_viewer) begin
			fb_nxt.width  = VRAM_WIDTH;
			fb_nxt.height = VRAM_HEIGHT;
			fb_nxt.base   = FB_BASE;
		end else begin
			fb_nxt.width  = geom.width;
			fb_nxt.height = geom.height;
			// Two bytes per pixel, one stride per line
			fb_nxt.base   = FB_BASE + (32'(geom.offset_x) << 1) + 32'(geom.offset_y) * FB_STRIDE;
		end
	end

	// Original ratio is 4:3, or 2:1 for the whole VRAM
	always_comb begin
		if (status.aspect == 2'd0) begin
			aspect_nxt.arx = status.vram_viewer ? 13'd2 : 13'd4;
			aspect_nxt.ary = status.vram_viewer ? 13'd1 : 13'd3;
		end else begin
			aspect_nxt.arx = 13'(status.aspect) - 13'd1;
			aspect_nxt.ary = 13'd0;
		end
	end

	assign sl_nxt = (status.scale == 3'd0) ? 3'd0 : status.scale - 3'd1;

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			fb_cfg <= '0;
			aspect <= '0;
			vga_sl <= 2'b00;
			vga_f1 <= 1'b0;
		end else begin
			fb_cfg <= fb_nxt;
			aspect <= aspect_nxt;
			vga_sl <= sl_nxt[1:0];
			// No field flag with the framebuffer or bob deinterlacing
			vga_f1 <= ~status.fb_enable & video_interlace & ~status.deint_bob;
		end
	end

endmodule

/* media_tracker.sv */
// Media tracker
// Keeps mounted CD and memory card state and raises card load and save pulses
`timescale 1ns/1ps

module media_tracker (
	input  logic                        clk_1x,
	input  logic                        arst_n,
	input  logic [3:0]                  img_mounted,
	input  logic [63:0]                 img_size,
	input  psx_cfg_pkg::host_status_t   status,
	input  logic                        osd_status,
	input  logic                        exe_dl,
	output psx_cfg_pkg::media_state_t   media,
	output logic                        mc1_load,
	output logic                        mc2_load,
	output logic                        mc_save,
	output logic                        cart_loaded
);
	import psx_cfg_pkg::*;

	media_state_t media_nxt;
	logic         size_nz;
	logic         save_auto;
	logic         old_load;
	logic         old_save;
	logic         old_save_auto;
	logic         load_edge;
	logic         save_edge;

	// Zero size means the image was unmounted
	assign size_nz = |img_size;

	// Autosave fires when the menu opens
	assign save_auto = osd_status & status.bk_autosave;

	assign load_edge = status.bk_load & ~old_load;
	assign save_edge = (status.bk_save & ~old_save) | (save_auto & ~old_save_auto);

	// ==================================================
	// Mount state
	// ==================================================

	always_comb begin
		media_nxt = media;
		// Slot 1 is the CD
		if (img_mounted[1]) begin
			media_nxt.has_cd = size_nz;
			if (size_nz) begin
				media_nxt.cd_hps_on = 1'b1;
				media_nxt.cd_size   = img_size[29:0];
			end
		end
		// Slots 2 and 3 are the memory cards
		if (img_mounted[2]) begin
			media_nxt.mc1_mounted = size_nz;
		end
		if (img_mounted[3]) begin
			media_nxt.mc2_mounted = size_nz;
		end
	end

	// ==================================================
	// Registered state and pulses
	// ==================================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			media         <= '0;
			mc1_load      <= 1'b0;
			mc2_load      <= 1'b0;
			mc_save       <= 1'b0;
			cart_loaded   <= 1'b0;
			old_load      <= 1'b0;
			old_save      <= 1'b0;
			old_save_auto <= 1'b0;
		end else begin
			media <= media_nxt;

			// Fresh mount or menu reload
			mc1_load <= (img_mounted[2] & size_nz) | load_edge;
			mc2_load <= (img_mounted[3] & size_nz) | load_edge;
			mc_save  <= save_edge;

			old_load      <= status.bk_load;
			old_save      <= status.bk_save;
			old_save_auto <= save_auto;

			// Sticky until reset
			if (exe_dl | img_mounted[1]) begin
				cart_loaded <= 1'b1;
			end
		end
	end

endmodule

/* ram_write_arbiter.sv */
// SDRAM channel arbiter
// Download writes own the write channel while a download runs, otherwise
// core requests are split onto the read and write channels
`timescale 1ns/1ps

module ram_write_arbiter (
	input  logic                       dl_active,
	input  psx_mem_pkg::ram_wr_t       dl_wr,
	input  psx_mem_pkg::core_ram_req_t core_req,
	input  logic                       sdram_rd_ack,
	input  logic                       sdram_wr_ack,
	output logic                       sdram_rd_req,
	output psx_mem_pkg::ram_addr_t     sdram_rd_addr,
	output psx_mem_pkg::ram_wr_t       sdram_wr,
	output logic                       core_ack
);
	import psx_mem_pkg::*;

	ram_wr_t core_wr;
	ram_wr_t load_wr;

	// Core write as seen on the write channel
	always_comb begin
		core_wr.req  = core_req.ena & ~core_req.rnw;
		core_wr.addr = core_req.addr;
		core_wr.data = core_req.data;
		core_wr.be   = core_req.be;
	end

	// Downloads always write whole words
	always_comb begin
		load_wr    = dl_wr;
		load_wr.be = 4'b1111;
	end

	assign sdram_wr = dl_active ? load_wr : core_wr;

	// Core reads are held off during a download
	assign sdram_rd_req  = core_req.ena & core_req.rnw & ~dl_active;
	assign sdram_rd_addr = core_req.addr;

	assign core_ack = sdram_rd_ack | sdram_wr_ack;

endmodule

/* download_unpacker.sv */
// Download unpacker
// Pairs 16-bit host download words into 32-bit RAM writes at the image
// base address and stalls the host until the RAM takes each write
`timescale 1ns/1ps

module download_unpacker #(
	parameter psx_mem_pkg::ram_addr_t BIOS_START = psx_mem_pkg::BIOS_BASE,
	parameter psx_mem_pkg::ram_addr_t EXE_START  = psx_mem_pkg::EXE_BASE
) (
	input  logic                   clk_1x,
	input  logic                   arst_n,
	input  logic                   ioctl_download,
	input  logic [7:0]             ioctl_index,
	input  logic                   ioctl_wr,
	input  psx_mem_pkg::ram_addr_t ioctl_addr,
	input  logic [15:0]            ioctl_dout,
	input  logic                   wr_ack,
	output logic                   ioctl_wait,
	output psx_mem_pkg::ram_wr_t   dl_wr,
	output logic                   dl_active,
	output logic                   exe_dl,
	output logic                   load_exe
);
	import psx_mem_pkg::*;

	logic        bios_dl;
	logic [1:0]  exe_hist;
	logic        host_wr;
	logic        high_word;
	logic        wr_req;
	ram_addr_t   wr_addr;
	logic [31:0] wr_data;

	assign dl_active = bios_dl | exe_dl;
	assign host_wr   = ioctl_wr & dl_active;
	// Bit 1 of the byte address selects the upper half
	assign high_word = host_wr & ioctl_addr[1];

	// ==================================================
	// Download kind, stall and end of executable
	// ==================================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			bios_dl    <= 1'b0;
			exe_dl     <= 1'b0;
			exe_hist   <= 2'b00;
			wr_req     <= 1'b0;
			ioctl_wait <= 1'b0;
			load_exe   <= 1'b0;
		end else begin
			bios_dl <= ioctl_download & (ioctl_index == IDX_BIOS);
			exe_dl  <= ioctl_download & (ioctl_index == IDX_EXE);

			// Single cycle request per word pair
			wr_req <= high_word;

			if (!dl_active) begin
				ioctl_wait <= 1'b0;
			end else if (high_word) begin
				ioctl_wait <= 1'b1;
			end else if (wr_ack) begin
				ioctl_wait <= 1'b0;
			end

			// Falling edge of exe_dl, seen two cycles late
			exe_hist <= {exe_hist[0], exe_dl};
			load_exe <= exe_hist[1] & ~exe_hist[0];
		end
	end

	// Word assembly
	always_ff @(posedge clk_1x) begin
		if (host_wr) begin
			if (!ioctl_addr[1]) begin
				wr_data[15:0] <= ioctl_dout;
				wr_addr       <= ioctl_addr + (exe_dl ? EXE_START : BIOS_START);
			end else begin
				wr_data[31:16] <= ioctl_dout;
			end
		end
	end

	always_comb begin
		dl_wr.req  = wr_req;
		dl_wr.addr = wr_addr;
		dl_wr.data = wr_data;
		dl_wr.be   = 4'b1111;
	end

endmodule

/* psx_cfg_pkg.sv */
// PSX host bridge configuration definitions
// Menu option word, display geometry, video and media state words

package psx_cfg_pkg;

	// ==================================================
	// Host side inputs
	// ==================================================

	// Menu options used by the bridge
	typedef struct packed {
		logic       bk_load;
		logic       bk_save;
		logic       bk_autosave;
		logic       fb_enable;
		logic       fb_24bit;
		logic       vram_viewer;
		logic [2:0] scale;
		logic [1:0] aspect;
		logic       deint_bob;
		// Region select, passed on to the core
		logic [1:0] cd_region;
	} host_status_t;

	// Visible area as reported by the core
	typedef struct packed {
		logic [11:0] width;
		logic [11:0] height;
		logic [9:0]  offset_x;
		logic [8:0]  offset_y;
	} display_geom_t;

	// ==================================================
	// Video and media outputs
	// ==================================================

	typedef struct packed {
		logic        en;
		logic [4:0]  format;
		logic [11:0] width;
		logic [11:0] height;
		logic [31:0] base;
	} fb_cfg_t;

	typedef struct packed {
		logic [12:0] arx;
		logic [12:0] ary;
	} aspect_t;

	typedef struct packed {
		logic        has_cd;
		logic        cd_hps_on;
		logic [29:0] cd_size;
		logic        mc1_mounted;
		logic        mc2_mounted;
	} media_state_t;

	localparam logic [31:0] FB_BASE_ADDR    = 32'h3000_0000;
	localparam logic [31:0] FB_STRIDE_BYTES = 32'd2048;

	// Framebuffer pixel formats, 24bpp RGB and 16bpp 1555
	localparam logic [4:0] FB_FMT_24BPP = 5'b00101;
	localparam logic [4:0] FB_FMT_16BPP = 5'b01100;

	// Whole VRAM shown by the viewer
	localparam logic [11:0] VRAM_WIDTH  = 12'd1024;
	localparam logic [11:0] VRAM_HEIGHT = 12'd512;

endpackage

/* psx_mem_pkg.sv */
// PSX host bridge memory definitions
// RAM byte address map, host download kinds and SDRAM request words

package psx_mem_pkg;

	// ==================================================
	// Address map
	// ==================================================

	localparam int RAM_ADDR_W = 27;

	typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

	// Image load addresses in RAM
	localparam ram_addr_t BIOS_BASE = 27'd2097152;
	localparam ram_addr_t EXE_BASE  = 27'd4194304;

	// Host download index values
	localparam logic [7:0] IDX_BIOS = 8'd0;
	localparam logic [7:0] IDX_EXE  = 8'd1;

	// ==================================================
	// RAM requests
	// ==================================================

	// One write on the SDRAM write channel
	typedef struct packed {
		logic        req;
		ram_addr_t   addr;
		logic [31:0] data;
		logic [3:0]  be;
	} ram_wr_t;

	// Core request, read when rnw is set
	typedef struct packed {
		logic        ena;
		logic        rnw;
		ram_addr_t   addr;
		logic [31:0] data;
		logic [3:0]  be;
	} core_ram_req_t;

endpackage
